// File: Makefile
# Verilator simulation of the UALink memory port command engine

SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP      := tb_ualink_turbo
FILELIST := sources.f
OBJDIR   := obj_dir
LOG      := sim.log
PASS_MSG := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, log to $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: dv/tb_ualink_turbo.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench for the memory port command engine
// stimulus, reference memory model, m_axis scoreboard, report
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_ualink_turbo;

   localparam logic [15:0] WR_OP = 16'h0245;
   localparam logic [15:0] RD_OP = 16'h0145;
   localparam int WAIT_LIMIT = 2000;   // cycles per wait loop

   typedef logic [63:0] word_q_t [$];
   typedef logic [64:0] beat_q_t [$];  // {tlast, tdata}

   logic        axi_aclk;
   logic        axi_resetn;
   logic [63:0] s_axis_tdata;
   logic        s_axis_tvalid;
   logic        s_axis_tready;
   logic        s_axis_tlast;
   logic [63:0] m_axis_tdata;
   logic        m_axis_tvalid;
   logic        m_axis_tready;
   logic        m_axis_tlast;

   logic [63:0] ref_mem [256];
   beat_q_t     exp_q;
   logic [7:0]  wr_addrs [$];          // start addresses of earlier writes
   logic        back_pressure = 1'b0;
   int          err_count = 0;
   int          pass_count = 0;
   int          fail_count = 0;

   ualink_turbo_top #(.FIFO_DEPTH_BITS(4), .BURST_LEN(8)) u_ualink_turbo_top (
      .axi_aclk, .axi_resetn,
      .s_axis_tdata, .s_axis_tvalid, .s_axis_tready, .s_axis_tlast,
      .m_axis_tdata, .m_axis_tvalid, .m_axis_tready, .m_axis_tlast
   );

   initial begin
      axi_aclk = 1'b0;
      forever #2 axi_aclk = ~axi_aclk;
   end

   // expected m_axis words for one packet, updates the model memory on writes
   function automatic void ref_model(input word_q_t pkt, output beat_q_t beats);
      logic [15:0] op;
      logic [7:0]  a;
      beats = {};
      op = pkt[0][63:48];
      a  = pkt[0][7:0];
      if (op == WR_OP) begin
         for (int i = 1; i <= 8; i++) begin
            ref_mem[a] = pkt[i];
            a++;                       // wraps at 256
         end
      end else if (op == RD_OP) begin
         for (int i = 0; i < 8; i++) begin
            beats.push_back({i == 7, ref_mem[a]});
            a++;
         end
      end else begin
         foreach (pkt[i]) beats.push_back({i == pkt.size() - 1, pkt[i]});
      end
   endfunction

   function automatic void random_words(output word_q_t q, input int n);
      q = {};
      for (int i = 0; i < n; i++) q.push_back({$urandom, $urandom});
   endfunction

   task automatic end_run();
      $display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, err_count);
      if (err_count == 0 && fail_count == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   endtask

   task automatic give_up(input string what);
      $display("timeout: no progress while %s", what);
      err_count++;
      fail_count++;
      end_run();
   endtask

   task automatic send_packet(input word_q_t pkt);
      beat_q_t beats;
      int      waited;
      logic    moved;
      ref_model(pkt, beats);
      foreach (beats[i]) exp_q.push_back(beats[i]);
      foreach (pkt[i]) begin
         s_axis_tdata  = pkt[i];
         s_axis_tlast  = (i == pkt.size() - 1);
         s_axis_tvalid = 1'b1;
         waited = 0;
         do begin
            moved = s_axis_tready;     // holds until the next edge
            @(posedge axi_aclk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) give_up("sending a word on s_axis");
         end while (!moved);
      end
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
   endtask

   task automatic write_burst(input logic [7:0] addr, input word_q_t data);
      word_q_t pkt;
      pkt.push_back({WR_OP, 40'h0, addr});
      foreach (data[i]) pkt.push_back(data[i]);
      wr_addrs.push_back(addr);
      send_packet(pkt);
   endtask

   task automatic read_burst(input logic [7:0] addr);
      word_q_t pkt;
      pkt.push_back({RD_OP, 40'h0, addr});
      send_packet(pkt);
   endtask

   task automatic forward_packet(input int len);
      word_q_t pkt;
      random_words(pkt, len);
      if (pkt[0][63:48] == WR_OP || pkt[0][63:48] == RD_OP) pkt[0][63] = 1'b1;
      send_packet(pkt);
   endtask

   task automatic end_test(input string name, input int errs_before);
      int waited;
      waited = 0;
      while (exp_q.size() != 0) begin
         @(posedge axi_aclk);
         #1;
         waited++;
         if (waited > WAIT_LIMIT) give_up("waiting for the expected m_axis words");
      end
      repeat (8) @(posedge axi_aclk);  // room for a stray extra word to show up
      #1;
      if (err_count == errs_before) begin
         pass_count++;
         $display("PASS  %s", name);
      end else begin
         fail_count++;
         $display("FAIL  %s", name);
      end
   endtask

   // m_axis scoreboard, also drives tready
   initial begin : monitor
      logic [64:0] want;
      logic [64:0] held;
      logic        was_stalled;
      m_axis_tready = 1'b1;
      was_stalled   = 1'b0;
      held          = '0;
      forever begin
         @(posedge axi_aclk);
         #1;
         m_axis_tready = back_pressure ? ($urandom % 3 != 0) : 1'b1;
         if (axi_resetn) begin
            if (was_stalled && (!m_axis_tvalid || {m_axis_tlast, m_axis_tdata} !== held)) begin
               $display("m_axis word changed or dropped while stalled at %0t", $time);
               err_count++;
            end
            if (m_axis_tvalid && m_axis_tready) begin
               if (exp_q.size() == 0) begin
                  $display("extra word 0x%h on m_axis with nothing expected", m_axis_tdata);
                  err_count++;
               end else begin
                  want = exp_q.pop_front();
                  if (m_axis_tdata !== want[63:0]) begin
                     $display("ERROR m_axis_tdata expected 0x%h actual 0x%h", want[63:0],
                              m_axis_tdata);
                     err_count++;
                  end
                  if (m_axis_tlast !== want[64]) begin
                     $display("ERROR m_axis_tlast expected 0x%h actual 0x%h", want[64],
                              m_axis_tlast);
                     err_count++;
                  end
               end
            end
            was_stalled = m_axis_tvalid && !m_axis_tready;
            held        = {m_axis_tlast, m_axis_tdata};
         end
      end
   end

   initial begin : stimulus
      word_q_t data;
      int      errs;
      void'($urandom(55588));
      axi_resetn    = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
      repeat (10) @(posedge axi_aclk);
      #1;
      axi_resetn = 1'b1;

      errs = err_count;
      if (m_axis_tvalid !== 1'b0) begin
         $display("ERROR m_axis_tvalid expected 0x0 actual 0x%h", m_axis_tvalid);
         err_count++;
      end
      if (s_axis_tready !== 1'b1) begin
         $display("ERROR s_axis_tready expected 0x1 actual 0x%h", s_axis_tready);
         err_count++;
      end
      end_test("state after reset", errs);

      errs = err_count;
      random_words(data, 8);
      write_burst(8'($urandom), data);
      read_burst(wr_addrs[0]);
      end_test("write then read back", errs);

      errs = err_count;
      random_words(data, 8);
      write_burst(8'd0, data);
      random_words(data, 8);
      write_burst(8'd252, data);       // lands on 252..255 and 0..3
      read_burst(8'd252);
      read_burst(8'd0);
      end_test("address wrap from 252", errs);

      errs = err_count;
      for (int i = 0; i < 4; i++) forward_packet(1 + $urandom % 6);
      end_test("unknown opcode forwarding", errs);

      errs = err_count;
      back_pressure = 1'b1;
      for (int i = 0; i < 40; i++) begin
         case ($urandom % 3)
            0: begin
               random_words(data, 8);
               write_burst(8'($urandom), data);
            end
            1: read_burst(wr_addrs[$urandom % wr_addrs.size()]);
            default: forward_packet(1 + $urandom % 6);
         endcase
      end
      end_test("mixed traffic under back-pressure", errs);
      back_pressure = 1'b0;
      end_run();
   end

endmodule

// File: hw/cmd_decode.sv
// ~~~~~~~~~~~~~~~~~~~~
// header decode and packet sequencer
// steers each packet to the write, read or forward path
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cmd_decode #(
   parameter int BURST_LEN = 8
) (
   input  logic                    axi_aclk,
   input  logic                    axi_resetn,

   // from the ingress FIFO
   input  ualink_pkg::word_t       fifo_data,
   input  logic                    fifo_last,
   input  logic                    fifo_valid,
   output logic                    fifo_pop,

   // command side of the memory engine
   output logic                    cmd_start,
   output logic                    cmd_is_read,
   output ualink_pkg::ram_addr_t   cmd_addr,
   output logic                    wr_valid,
   output ualink_pkg::word_t       wr_data,
   input  logic                    exec_busy,

   // forward path to the output stage
   output logic                    fwd_valid,
   output ualink_pkg::word_t       fwd_data,
   output logic                    fwd_last,
   input  logic                    fwd_ready
);

   localparam ualink_pkg::burst_cnt_t LAST_BEAT = ualink_pkg::burst_cnt_t'(BURST_LEN - 1);

   ualink_pkg::decode_state_t state;
   ualink_pkg::decode_state_t state_next;
   ualink_pkg::burst_cnt_t    wr_cnt;
   ualink_pkg::opcode_t       opcode;

   // header fields, only meaningful in idle
   assign opcode      = fifo_data[ualink_pkg::OPCODE_MSB:ualink_pkg::OPCODE_LSB];
   assign cmd_addr    = fifo_data[ualink_pkg::ADDR_LSB +: $bits(ualink_pkg::ram_addr_t)];
   assign cmd_is_read = (opcode == ualink_pkg::OP_READ);

   // payload goes straight from the FIFO head
   assign wr_data  = fifo_data;
   assign fwd_data = fifo_data;
   assign fwd_last = fifo_last;

   always_comb begin
      state_next = state;
      cmd_start  = 1'b0;
      fifo_pop   = 1'b0;
      wr_valid   = 1'b0;
      fwd_valid  = 1'b0;
      case (state)
         ualink_pkg::dec_idle: begin
            // nothing new starts until the engine has drained
            if (fifo_valid && !exec_busy) begin
               if (opcode == ualink_pkg::OP_WRITE) begin
                  cmd_start  = 1'b1;
                  fifo_pop   = 1'b1;
                  state_next = ualink_pkg::dec_wr_data;
               end else if (opcode == ualink_pkg::OP_READ) begin
                  cmd_start  = 1'b1;
                  fifo_pop   = 1'b1;
                  state_next = ualink_pkg::dec_rd_wait;
               end else begin
                  fwd_valid = 1'b1;   // header goes out as the first word
                  if (fwd_ready) begin
                     fifo_pop = 1'b1;
                     if (!fifo_last) state_next = ualink_pkg::dec_fwd;
                  end
               end
            end
         end
         ualink_pkg::dec_fwd: begin
            fwd_valid = fifo_valid;
            if (fifo_valid && fwd_ready) begin
               fifo_pop = 1'b1;
               if (fifo_last) state_next = ualink_pkg::dec_idle;
            end
         end
         ualink_pkg::dec_wr_data: begin
            // memory takes a word every cycle, no handshake needed
            wr_valid = fifo_valid;
            fifo_pop = fifo_valid;
            if (fifo_valid && wr_cnt == LAST_BEAT) state_next = ualink_pkg::dec_idle;
         end
         ualink_pkg::dec_rd_wait: begin
            if (!exec_busy) state_next = ualink_pkg::dec_idle;
         end
         default: state_next = ualink_pkg::dec_idle;
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state  <= ualink_pkg::dec_idle;
         wr_cnt <= '0;
      end else begin
         state <= state_next;
         if (cmd_start)     wr_cnt <= '0;
         else if (wr_valid) wr_cnt <= wr_cnt + ualink_pkg::burst_cnt_t'(1);
      end
   end

endmodule

// File: hw/ingress_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~
// ingress FIFO for the slave stream
// first-word-fall-through, data and tlast side by side
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ingress_fifo #(
   parameter int FIFO_DEPTH_BITS = 4
) (
   input  logic                axi_aclk,
   input  logic                axi_resetn,

   // slave stream
   input  ualink_pkg::word_t   s_axis_tdata,
   input  logic                s_axis_tlast,
   input  logic                s_axis_tvalid,
   output logic                s_axis_tready,

   // head of queue
   output ualink_pkg::word_t   fifo_data,
   output logic                fifo_last,
   output logic                fifo_valid,
   input  logic                fifo_pop
);

   localparam int DEPTH = 2 ** FIFO_DEPTH_BITS;

   typedef logic [FIFO_DEPTH_BITS-1:0] ptr_t;
   typedef logic [FIFO_DEPTH_BITS:0]   count_t;   // one extra bit to tell full from empty

   ualink_pkg::word_t data_mem [DEPTH];
   logic              last_mem [DEPTH];

   ptr_t   wr_ptr;
   ptr_t   rd_ptr;
   count_t count;
   logic   push;
   logic   pop;

   assign s_axis_tready = (count != count_t'(DEPTH));   // stall only when full
   assign fifo_valid    = (count != '0);
   assign push          = s_axis_tvalid && s_axis_tready;
   assign pop           = fifo_pop && fifo_valid;

   // oldest entry straight from the array, no read delay
   assign fifo_data = data_mem[rd_ptr];
   assign fifo_last = last_mem[rd_ptr];

   always_ff @(posedge axi_aclk) begin
      if (push) begin
         data_mem[wr_ptr] <= s_axis_tdata;
         last_mem[wr_ptr] <= s_axis_tlast;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + ptr_t'(1);   // pointers wrap at DEPTH
         if (pop)  rd_ptr <= rd_ptr + ptr_t'(1);
         case ({push, pop})
            2'b10:   count <= count + count_t'(1);
            2'b01:   count <= count - count_t'(1);
            default: count <= count;   // both or neither
         endcase
      end
   end

endmodule

// File: hw/mem_execute.sv
// ~~~~~~~~~~~~~~~~~~~~
// 256 x 64 memory with write and read burst engines
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mem_execute #(
   parameter int BURST_LEN = 8
) (
   input  logic                    axi_aclk,
   input  logic                    axi_resetn,
   input  logic                    cmd_start,
   input  logic                    cmd_is_read,
   input  ualink_pkg::ram_addr_t   cmd_addr,
   input  logic                    wr_valid,
   input  ualink_pkg::word_t       wr_data,
   output logic                    exec_busy,
   output logic                    rd_valid,
   output ualink_pkg::word_t       rd_data,
   output logic                    rd_last,
   input  logic                    rd_ready
);

   localparam int MEM_DEPTH = 2 ** $bits(ualink_pkg::ram_addr_t);
   localparam ualink_pkg::burst_cnt_t LAST_BEAT = ualink_pkg::burst_cnt_t'(BURST_LEN - 1);

   ualink_pkg::word_t       mem [MEM_DEPTH];
   ualink_pkg::exec_state_t state;
   ualink_pkg::ram_addr_t   addr;        // wraps modulo 256
   ualink_pkg::burst_cnt_t  beat;
   logic                    issue_done;  // all read beats sent to the RAM
   logic                    wr_beat;
   logic                    rd_issue;

   assign exec_busy = (state != ualink_pkg::exec_idle);
   assign wr_beat   = (state == ualink_pkg::exec_write) && wr_valid;

   // issue a read when the output register is empty or moving this cycle
   assign rd_issue = (state == ualink_pkg::exec_read) && !issue_done && (!rd_valid || rd_ready);

   always_ff @(posedge axi_aclk) begin
      if (wr_beat) mem[addr] <= wr_data;
      if (rd_issue) begin
         rd_data <= mem[addr];            // one cycle RAM latency
         rd_last <= (beat == LAST_BEAT);
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state      <= ualink_pkg::exec_idle;
         addr       <= '0;
         beat       <= '0;
         issue_done <= 1'b0;
         rd_valid   <= 1'b0;
      end else begin
         if (rd_issue)      rd_valid <= 1'b1;
         else if (rd_ready) rd_valid <= 1'b0;
         case (state)
            ualink_pkg::exec_idle: begin
               if (cmd_start) begin
                  addr       <= cmd_addr;
                  beat       <= '0;
                  issue_done <= 1'b0;
                  state      <= cmd_is_read ? ualink_pkg::exec_read : ualink_pkg::exec_write;
               end
            end
            ualink_pkg::exec_write: begin
               if (wr_valid) begin
                  addr <= addr + ualink_pkg::ram_addr_t'(1);
                  beat <= beat + ualink_pkg::burst_cnt_t'(1);
                  if (beat == LAST_BEAT) state <= ualink_pkg::exec_idle;
               end
            end
            ualink_pkg::exec_read: begin
               if (rd_issue) begin
                  addr <= addr + ualink_pkg::ram_addr_t'(1);
                  beat <= beat + ualink_pkg::burst_cnt_t'(1);
                  if (beat == LAST_BEAT) issue_done <= 1'b1;
               end
               // done once the last word is handed over
               if (rd_valid && rd_ready && rd_last) state <= ualink_pkg::exec_idle;
            end
            default: state <= ualink_pkg::exec_idle;
         endcase
      end
   end

endmodule

// File: hw/rsp_stream.sv
// ~~~~~~~~~~~~~~~~~~~~
// output stage onto the master stream
// merges forward and read paths, two-entry skid buffer
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module rsp_stream (
   input  logic                axi_aclk,
   input  logic                axi_resetn,

   input  logic                fwd_valid,
   input  ualink_pkg::word_t   fwd_data,
   input  logic                fwd_last,
   output logic                fwd_ready,

   input  logic                rd_valid,
   input  ualink_pkg::word_t   rd_data,
   input  logic                rd_last,
   output logic                rd_ready,

   output ualink_pkg::word_t   m_axis_tdata,
   output logic                m_axis_tvalid,
   output logic                m_axis_tlast,
   input  logic                m_axis_tready
);

   ualink_pkg::word_t in_data;
   logic              in_last;
   logic              in_valid;
   logic              accept;
   logic              out_stall;

   // second entry
   ualink_pkg::word_t skid_data;
   logic              skid_last;
   logic              skid_valid;

   // sources are never active together
   assign in_valid = fwd_valid || rd_valid;
   assign in_data  = rd_valid ? rd_data : fwd_data;
   assign in_last  = rd_valid ? rd_last : fwd_last;

   assign fwd_ready = !skid_valid;
   assign rd_ready  = !skid_valid;
   assign accept    = in_valid && !skid_valid;
   assign out_stall = m_axis_tvalid && !m_axis_tready;

   always_ff @(posedge axi_aclk) begin
      if (out_stall) begin
         if (accept) begin   // park it behind the stalled word
            skid_data <= in_data;
            skid_last <= in_last;
         end
      end else if (skid_valid) begin
         m_axis_tdata <= skid_data;
         m_axis_tlast <= skid_last;
      end else if (accept) begin
         m_axis_tdata <= in_data;
         m_axis_tlast <= in_last;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         m_axis_tvalid <= 1'b0;
         skid_valid    <= 1'b0;
      end else if (out_stall) begin
         if (accept) skid_valid <= 1'b1;
      end else begin
         m_axis_tvalid <= skid_valid || accept;
         skid_valid    <= 1'b0;   // skid drains into the output
      end
   end

endmodule

// File: hw/ualink_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// shared types and constants for the command engine
// word and address typedefs, opcodes, header fields, FSM states
// ~~~~~~~~~~~~~~~~~~~~

package ualink_pkg;

   // stream and memory word
   typedef logic [63:0] word_t;

   // 256-deep memory, so 8-bit addresses wrap on their own
   typedef logic [7:0]  ram_addr_t;
   typedef logic [15:0] opcode_t;

   // beat counter, sized for an eight word burst
   typedef logic [2:0]  burst_cnt_t;

   localparam opcode_t OP_WRITE = 16'h0245;   // header + 8 data words
   localparam opcode_t OP_READ  = 16'h0145;   // header only, 8 words back

   // header field positions
   localparam int OPCODE_MSB = 63;
   localparam int OPCODE_LSB = 48;
   localparam int ADDR_LSB   = 0;    // width follows ram_addr_t

   typedef enum logic [1:0] {
      dec_idle,      // waiting for a header at the FIFO head
      dec_fwd,       // passing an unknown packet through
      dec_wr_data,   // feeding write data to the memory
      dec_rd_wait    // read burst in progress
   } decode_state_t;

   typedef enum logic [1:0] {
      exec_idle,
      exec_write,
      exec_read
   } exec_state_t;

endpackage

// File: hw/ualink_turbo_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// top level of the memory port command engine
// FIFO, decode, memory engine and output stage
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ualink_turbo_top #(
   parameter int FIFO_DEPTH_BITS = 4,
   parameter int BURST_LEN       = 8
) (
   input  logic                axi_aclk,
   input  logic                axi_resetn,

   input  ualink_pkg::word_t   s_axis_tdata,
   input  logic                s_axis_tvalid,
   output logic                s_axis_tready,
   input  logic                s_axis_tlast,

   output ualink_pkg::word_t   m_axis_tdata,
   output logic                m_axis_tvalid,
   input  logic                m_axis_tready,
   output logic                m_axis_tlast
);

   ualink_pkg::word_t     fifo_data;
   logic                  fifo_last;
   logic                  fifo_valid;
   logic                  fifo_pop;
   logic                  cmd_start;
   logic                  cmd_is_read;
   ualink_pkg::ram_addr_t cmd_addr;
   logic                  wr_valid;
   ualink_pkg::word_t     wr_data;
   logic                  exec_busy;
   logic                  fwd_valid;
   ualink_pkg::word_t     fwd_data;
   logic                  fwd_last;
   logic                  fwd_ready;
   logic                  rd_valid;
   ualink_pkg::word_t     rd_data;
   logic                  rd_last;
   logic                  rd_ready;

   ingress_fifo #(.FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)) u_ingress_fifo (
      .axi_aclk, .axi_resetn,
      .s_axis_tdata, .s_axis_tlast, .s_axis_tvalid, .s_axis_tready,
      .fifo_data, .fifo_last, .fifo_valid, .fifo_pop
   );

   cmd_decode #(.BURST_LEN(BURST_LEN)) u_cmd_decode (
      .axi_aclk, .axi_resetn,
      .fifo_data, .fifo_last, .fifo_valid, .fifo_pop,
      .cmd_start, .cmd_is_read, .cmd_addr, .wr_valid, .wr_data, .exec_busy,
      .fwd_valid, .fwd_data, .fwd_last, .fwd_ready
   );

   mem_execute #(.BURST_LEN(BURST_LEN)) u_mem_execute (
      .axi_aclk, .axi_resetn,
      .cmd_start, .cmd_is_read, .cmd_addr, .wr_valid, .wr_data, .exec_busy,
      .rd_valid, .rd_data, .rd_last, .rd_ready
   );

   rsp_stream u_rsp_stream (
      .axi_aclk, .axi_resetn,
      .fwd_valid, .fwd_data, .fwd_last, .fwd_ready,
      .rd_valid, .rd_data, .rd_last, .rd_ready,
      .m_axis_tdata, .m_axis_tvalid, .m_axis_tlast, .m_axis_tready
   );

endmodule

// File: sources.f
hw/ualink_pkg.sv
hw/ingress_fifo.sv
hw/cmd_decode.sv
hw/mem_execute.sv
hw/rsp_stream.sv
hw/ualink_turbo_top.sv
dv/tb_ualink_turbo.sv
